//--- source/riscvPkg.sv
package riscvPkg;

   localparam int addrWidth = 12;

   // major opcodes of the supported subset
   localparam logic [6:0] opLui    = 7'b0110111;
   localparam logic [6:0] opJal    = 7'b1101111;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opLoad   = 7'b0000011;
   localparam logic [6:0] opStore  = 7'b0100011;
   localparam logic [6:0] opImm    = 7'b0010011;
   localparam logic [6:0] opReg    = 7'b0110011;
   localparam logic [6:0] opSystem = 7'b1110011;

   localparam logic [3:0] aluAdd   = 4'd0;
   localparam logic [3:0] aluSub   = 4'd1;
   localparam logic [3:0] aluAnd   = 4'd2;
   localparam logic [3:0] aluOr    = 4'd3;
   localparam logic [3:0] aluXor   = 4'd4;
   localparam logic [3:0] aluSlt   = 4'd5;
   localparam logic [3:0] aluSll   = 4'd6;
   localparam logic [3:0] aluSrl   = 4'd7;
   localparam logic [3:0] aluPassB = 4'd8;  // lui

   // register write source
   localparam logic [1:0] rwAlu  = 2'd0;
   localparam logic [1:0] rwMem  = 2'd1;
   localparam logic [1:0] rwLink = 2'd2;

   localparam logic [1:0] fwdNone = 2'd0;
   localparam logic [1:0] fwdMem  = 2'd1;
   localparam logic [1:0] fwdWb   = 2'd2;

   localparam logic [31:0] nopInstr  = 32'h0000_0013;  // addi x0,x0,0
   localparam logic [31:0] haltInstr = 32'h0010_0073;  // ebreak

   // one instruction word, seen through each encoding format
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] immHi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] immLo;
         logic [6:0] opcode;
      } s;
      struct packed {
         logic       imm12;
         logic [5:0] imm10_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [3:0] imm4_1;
         logic       imm11;
         logic [6:0] opcode;
      } b;
      struct packed {
         logic [19:0] imm;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
      struct packed {
         logic       imm20;
         logic [9:0] imm10_1;
         logic       imm11;
         logic [7:0] imm19_12;
         logic [4:0] rd;
         logic [6:0] opcode;
      } j;
   } instrWord_u;

endpackage

//--- source/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
   input  logic                           CLK,
   input  logic                           RSTn,
   input  logic                           stall,
   input  logic                           redirect,
   input  logic [31:0]                    redirectPc,
   output logic                           iMemCsn,
   output logic [riscvPkg::addrWidth-1:0] iMemAddr,
   input  logic [31:0]                    iMemData,
   output riscvPkg::instrWord_u           instrId,
   output logic [31:0]                    pcId,
   output logic                           validId
);
   import riscvPkg::*;

   logic [31:0] pc;
   logic        csnReg;

   assign iMemCsn  = csnReg;
   assign iMemAddr = pc[addrWidth-1:0];  // byte address

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc      <= 32'd0;
         csnReg  <= 1'b1;
         instrId <= nopInstr;
         validId <= 1'b0;
      end else begin
         csnReg <= 1'b0;
         if (redirect) begin
            // both younger slots die, this one here
            pc      <= redirectPc;
            instrId <= nopInstr;
            validId <= 1'b0;
         end else if (!stall && !csnReg) begin
            pc      <= pc + 32'd4;
            instrId <= iMemData;
            pcId    <= pc;
            validId <= 1'b1;
         end
      end
   end

   alignedFetch: assert property (@(posedge CLK) disable iff (RSTn)
      iMemAddr[1:0] == 2'b00);

endmodule

//--- source/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
   input  logic                 CLK,
   input  logic                 RSTn,
   input  riscvPkg::instrWord_u instrId,
   input  logic [31:0]          pcId,
   input  logic                 validId,
   input  logic                 flush,
   input  logic [31:0]          rfRd1,
   input  logic [31:0]          rfRd2,
   input  logic                 wbWe,
   input  logic [4:0]           wbWa,
   input  logic [31:0]          wbWd,
   output logic [4:0]           rfRa1,
   output logic [4:0]           rfRa2,
   output logic                 stall,
   output logic                 exValid,
   output logic [31:0]          exPc,
   output logic [4:0]           exRs1,
   output logic [4:0]           exRs2,
   output logic [31:0]          exOp1,
   output logic [31:0]          exOp2,
   output logic [31:0]          exImm,
   output logic [3:0]           exAluOp,
   output logic                 exSrcPc,
   output logic                 exSrcImm,
   output logic                 exMemRead,
   output logic                 exMemWrite,
   output logic [1:0]           exRwSrc,
   output logic                 exRegWrite,
   output logic [4:0]           exWa,
   output logic                 exBranch,
   output logic                 exBranchNe,
   output logic                 exJump,
   output logic                 exHalt
);
   import riscvPkg::*;

   logic [6:0]  opcode;
   logic        useRs1, useRs2, bubble;
   logic [31:0] imm, rd1, rd2;
   logic [3:0]  aluSel, aluOp;
   logic [1:0]  rwSrc;
   logic        srcPc, srcImm, memRead, memWrite, regWrite, branch, jump, isHalt;

   assign opcode = instrId.r.opcode;
   assign useRs1 = !(opcode inside {opLui, opJal});
   assign useRs2 = opcode inside {opReg, opStore, opBranch};
   assign rfRa1  = useRs1 ? instrId.r.rs1 : 5'd0;  // x0 never matches a hazard
   assign rfRa2  = useRs2 ? instrId.r.rs2 : 5'd0;

   // same-cycle writeback bypass
   assign rd1 = (wbWe && wbWa == rfRa1) ? wbWd : rfRd1;
   assign rd2 = (wbWe && wbWa == rfRa2) ? wbWd : rfRd2;

   // load in EX feeding ID
   assign stall = validId && exMemRead &&
                  ((rfRa1 != 5'd0 && exWa == rfRa1) || (rfRa2 != 5'd0 && exWa == rfRa2));
   assign bubble = flush || stall || !validId;

   always_comb begin
      case (opcode)
         opStore: imm = {{20{instrId.s.immHi[6]}}, instrId.s.immHi, instrId.s.immLo};
         opBranch: imm = {{20{instrId.b.imm12}}, instrId.b.imm11, instrId.b.imm10_5,
                          instrId.b.imm4_1, 1'b0};
         opLui: imm = {instrId.u.imm, 12'd0};
         opJal: imm = {{12{instrId.j.imm20}}, instrId.j.imm19_12, instrId.j.imm11,
                       instrId.j.imm10_1, 1'b0};
         default: imm = {{20{instrId.i.imm[11]}}, instrId.i.imm};
      endcase
   end

   always_comb begin
      case (instrId.r.funct3)
         3'b001: aluSel = aluSll;
         3'b010: aluSel = aluSlt;
         3'b100: aluSel = aluXor;
         3'b101: aluSel = aluSrl;
         3'b110: aluSel = aluOr;
         3'b111: aluSel = aluAnd;
         default: aluSel = (opcode == opReg && instrId.r.funct7[5]) ? aluSub : aluAdd;
      endcase
   end

   always_comb begin
      aluOp    = aluAdd;
      rwSrc    = rwAlu;
      srcPc    = 1'b0;
      srcImm   = 1'b1;
      memRead  = 1'b0;
      memWrite = 1'b0;
      regWrite = 1'b0;
      branch   = 1'b0;
      jump     = 1'b0;
      isHalt   = 1'b0;
      case (opcode)
         opReg: begin
            aluOp    = aluSel;
            srcImm   = 1'b0;
            regWrite = 1'b1;
         end
         opImm: begin
            aluOp    = aluSel;
            regWrite = 1'b1;
         end
         opLui: begin
            aluOp    = aluPassB;
            regWrite = 1'b1;
         end
         opLoad: begin
            memRead  = 1'b1;
            rwSrc    = rwMem;
            regWrite = 1'b1;
         end
         opStore: memWrite = 1'b1;
         opBranch: begin
            srcPc  = 1'b1;  // alu forms the target
            branch = 1'b1;
         end
         opJal: begin
            srcPc    = 1'b1;
            jump     = 1'b1;
            rwSrc    = rwLink;
            regWrite = 1'b1;
         end
         opSystem: isHalt = (instrId == haltInstr);
         default: ;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (RSTn || bubble) begin
         exValid    <= 1'b0;
         exMemRead  <= 1'b0;
         exMemWrite <= 1'b0;
         exRegWrite <= 1'b0;
         exBranch   <= 1'b0;
         exJump     <= 1'b0;
         exHalt     <= 1'b0;
      end else begin
         exValid    <= 1'b1;
         exMemRead  <= memRead;
         exMemWrite <= memWrite;
         exRegWrite <= regWrite && (instrId.r.rd != 5'd0);
         exBranch   <= branch;
         exJump     <= jump;
         exHalt     <= isHalt;
      end
      exPc       <= pcId;
      exRs1      <= rfRa1;
      exRs2      <= rfRa2;
      exOp1      <= rd1;
      exOp2      <= rd2;
      exImm      <= imm;
      exAluOp    <= aluOp;
      exSrcPc    <= srcPc;
      exSrcImm   <= srcImm;
      exRwSrc    <= rwSrc;
      exWa       <= instrId.r.rd;
      exBranchNe <= instrId.r.funct3[0];
   end

   // fetch must keep the stalled instruction in ID
   holdOnStall: assert property (@(posedge CLK) disable iff (RSTn)
      stall |=> $stable(instrId) && $stable(pcId));

endmodule

//--- source/execUnit.sv
`timescale 1ns/1ps

module execUnit (
   input  logic                           CLK,
   input  logic                           RSTn,
   input  logic                           exValid,
   input  logic [31:0]                    exPc,
   input  logic [4:0]                     exRs1,
   input  logic [4:0]                     exRs2,
   input  logic [31:0]                    exOp1,
   input  logic [31:0]                    exOp2,
   input  logic [31:0]                    exImm,
   input  logic [3:0]                     exAluOp,
   input  logic                           exSrcPc,
   input  logic                           exSrcImm,
   input  logic                           exMemRead,
   input  logic                           exMemWrite,
   input  logic [1:0]                     exRwSrc,
   input  logic                           exRegWrite,
   input  logic [4:0]                     exWa,
   input  logic                           exBranch,
   input  logic                           exBranchNe,
   input  logic                           exJump,
   input  logic                           exHalt,
   input  logic                           wbWe,
   input  logic [4:0]                     wbWa,
   input  logic [31:0]                    wbWd,
   output logic                           redirect,
   output logic [31:0]                    redirectPc,
   output logic                           dMemCsn,
   output logic                           dMemWen,
   output logic [riscvPkg::addrWidth-1:0] dMemAddr,
   output logic [31:0]                    dMemDout,
   output logic                           memValid,
   output logic                           memRegWrite,
   output logic [4:0]                     memWa,
   output logic [1:0]                     memRwSrc,
   output logic [31:0]                    memResult,
   output logic [31:0]                    memLink,
   output logic                           memHalt
);
   import riscvPkg::*;

   logic [1:0]  fwdA, fwdB;
   logic [31:0] rs1Val, rs2Val, memFwd, opA, opB, aluRes, memStore;
   logic        memRead, memWrite, taken;

   // loads in EX/MEM are excluded, decode stalls for them
   function automatic logic [1:0] fwdSel(input logic [4:0] rs);
      if (memRegWrite && memRwSrc != rwMem && memWa == rs)
         return fwdMem;
      else if (wbWe && wbWa == rs)
         return fwdWb;
      return fwdNone;
   endfunction

   function automatic logic [31:0] fwdVal(input logic [1:0] sel, input logic [31:0] regVal);
      case (sel)
         fwdMem: return memFwd;
         fwdWb: return wbWd;
         default: return regVal;
      endcase
   endfunction

   assign memFwd = (memRwSrc == rwLink) ? memLink : memResult;

   always_comb begin
      fwdA   = fwdSel(exRs1);
      fwdB   = fwdSel(exRs2);
      rs1Val = fwdVal(fwdA, exOp1);
      rs2Val = fwdVal(fwdB, exOp2);
   end

   assign opA = exSrcPc ? exPc : rs1Val;
   assign opB = exSrcImm ? exImm : rs2Val;

   always_comb begin
      case (exAluOp)
         aluAdd: aluRes = opA + opB;
         aluSub: aluRes = opA - opB;
         aluAnd: aluRes = opA & opB;
         aluOr: aluRes = opA | opB;
         aluXor: aluRes = opA ^ opB;
         aluSlt: aluRes = {31'd0, $signed(opA) < $signed(opB)};
         aluSll: aluRes = opA << opB[4:0];
         aluSrl: aluRes = opA >> opB[4:0];
         aluPassB: aluRes = opB;
         default: aluRes = 32'd0;
      endcase
   end

   assign taken      = exBranch && ((rs1Val == rs2Val) != exBranchNe);
   assign redirect   = exValid && (exJump || taken);
   assign redirectPc = aluRes;  // pc + imm for branch and jal

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         memValid    <= 1'b0;
         memRegWrite <= 1'b0;
         memRead     <= 1'b0;
         memWrite    <= 1'b0;
         memHalt     <= 1'b0;
      end else begin
         memValid    <= exValid;
         memRegWrite <= exRegWrite;
         memRead     <= exMemRead;
         memWrite    <= exMemWrite;
         memHalt     <= exHalt;
      end
      memWa     <= exWa;
      memRwSrc  <= exRwSrc;
      memResult <= aluRes;
      memLink   <= exPc + 32'd4;
      memStore  <= rs2Val;
   end

   // data memory, word addressed
   assign dMemCsn  = !(memRead || memWrite);
   assign dMemWen  = !memWrite;
   assign dMemAddr = memResult[addrWidth+1:2];
   assign dMemDout = memStore;

   // squashed slots never store
   writeFromValid: assert property (@(posedge CLK) disable iff (RSTn) !dMemWen |-> memValid);

endmodule

//--- source/writeBack.sv
`timescale 1ns/1ps

module writeBack (
   input  logic        CLK,
   input  logic        RSTn,
   input  logic        memValid,
   input  logic        memRegWrite,
   input  logic [4:0]  memWa,
   input  logic [1:0]  memRwSrc,
   input  logic [31:0] memResult,
   input  logic [31:0] memLink,
   input  logic        memHalt,
   input  logic [31:0] dMemData,
   output logic        rfWe,
   output logic [4:0]  rfWa,
   output logic [31:0] rfWd,
   output logic        halt,
   output logic [31:0] numInst
);
   import riscvPkg::*;

   logic        wbValid, wbRegWrite, wbHalt, haltSeen;
   logic [1:0]  wbRwSrc;
   logic [31:0] wbResult, wbLoad, wbLink;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         wbValid    <= 1'b0;
         wbRegWrite <= 1'b0;
         wbHalt     <= 1'b0;
         haltSeen   <= 1'b0;
         numInst    <= 32'd0;
      end else begin
         wbValid    <= memValid;
         wbRegWrite <= memRegWrite;
         wbHalt     <= memHalt;
         haltSeen   <= haltSeen || halt;
         if (memValid && !halt)
            numInst <= numInst + 32'd1;  // counted on entry to WB
      end
      rfWa     <= memWa;
      wbRwSrc  <= memRwSrc;
      wbResult <= memResult;
      wbLoad   <= dMemData;
      wbLink   <= memLink;
   end

   assign halt = haltSeen || (wbValid && wbHalt);
   assign rfWe = wbRegWrite && !halt;

   always_comb begin
      case (wbRwSrc)
         rwAlu: rfWd = wbResult;
         rwMem: rfWd = wbLoad;
         rwLink: rfWd = wbLink;
         default: rfWd = 32'd0;
      endcase
   end

   noZeroWrite: assert property (@(posedge CLK) disable iff (RSTn) rfWe |-> rfWa != 5'd0);

endmodule

//--- source/riscvTop.sv
`timescale 1ns/1ps

module riscvTop (
   input  logic                           CLK,
   input  logic                           RSTn,
   output logic                           iMemCsn,
   output logic [riscvPkg::addrWidth-1:0] iMemAddr,  // byte address
   input  logic [31:0]                    iMemData,
   output logic                           dMemCsn,
   output logic [riscvPkg::addrWidth-1:0] dMemAddr,  // word address
   output logic [31:0]                    dMemDout,
   input  logic [31:0]                    dMemData,
   output logic                           dMemWen,
   output logic                           rfWe,
   output logic [4:0]                     rfRa1,
   output logic [4:0]                     rfRa2,
   output logic [4:0]                     rfWa,
   input  logic [31:0]                    rfRd1,
   input  logic [31:0]                    rfRd2,
   output logic [31:0]                    rfWd,
   output logic                           halt,
   output logic [31:0]                    numInst
);
   import riscvPkg::*;

   instrWord_u  instrId;
   logic [31:0] pcId, redirectPc;
   logic        validId, stall, redirect;

   logic [31:0] exPc, exOp1, exOp2, exImm;
   logic [4:0]  exRs1, exRs2, exWa;
   logic [3:0]  exAluOp;
   logic [1:0]  exRwSrc;
   logic        exValid, exSrcPc, exSrcImm, exMemRead, exMemWrite, exRegWrite;
   logic        exBranch, exBranchNe, exJump, exHalt;

   logic [31:0] memResult, memLink;
   logic [4:0]  memWa;
   logic [1:0]  memRwSrc;
   logic        memValid, memRegWrite, memHalt;

   fetchUnit uFetch (
      .CLK, .RSTn, .stall, .redirect, .redirectPc,
      .iMemCsn, .iMemAddr, .iMemData, .instrId, .pcId, .validId
   );

   instrDecode uDecode (
      .CLK, .RSTn, .instrId, .pcId, .validId, .flush(redirect),
      .rfRd1, .rfRd2, .wbWe(rfWe), .wbWa(rfWa), .wbWd(rfWd), .rfRa1, .rfRa2, .stall,
      .exValid, .exPc, .exRs1, .exRs2, .exOp1, .exOp2, .exImm,
      .exAluOp, .exSrcPc, .exSrcImm, .exMemRead, .exMemWrite, .exRwSrc, .exRegWrite,
      .exWa, .exBranch, .exBranchNe, .exJump, .exHalt
   );

   execUnit uExec (
      .CLK, .RSTn, .exValid, .exPc, .exRs1, .exRs2, .exOp1, .exOp2, .exImm,
      .exAluOp, .exSrcPc, .exSrcImm, .exMemRead, .exMemWrite, .exRwSrc, .exRegWrite,
      .exWa, .exBranch, .exBranchNe, .exJump, .exHalt,
      .wbWe(rfWe), .wbWa(rfWa), .wbWd(rfWd), .redirect, .redirectPc,
      .dMemCsn, .dMemWen, .dMemAddr, .dMemDout,
      .memValid, .memRegWrite, .memWa, .memRwSrc, .memResult, .memLink, .memHalt
   );

   writeBack uWriteBack (
      .CLK, .RSTn, .memValid, .memRegWrite, .memWa, .memRwSrc, .memResult, .memLink,
      .memHalt, .dMemData, .rfWe, .rfWa, .rfWd, .halt, .numInst
   );

endmodule

//--- tests/tbModel.sv
package tbModel;
   import riscvPkg::*;

   localparam int progLen  = 160;
   localparam int memWords = 1024;

   // funct3 for add, sub, and, or, xor, slt, sll, srl
   localparam logic [2:0] aluF3 [0:7] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5};

   typedef struct packed {
      logic [1:0]  kind;  // 0 alu, 1 load, 2 link
      logic [4:0]  wa;
      logic [31:0] wd;
   } wrEntry_t;

   logic [31:0] prog [0:progLen];
   logic [31:0] modelMem [0:memWords-1];
   wrEntry_t    expWrites [$];
   int          retired;

   // every address bit changes the word
   function automatic logic [31:0] dataFill(input int idx);
      return (idx * 32'h9e37_79b9) ^ {idx[15:0], ~idx[15:0]};
   endfunction

   function automatic int pick(inout integer seed, input int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % n);
   endfunction

   function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return sub ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd4: return a ^ b;
         3'd5: return a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic genProgram(inout integer seed);
      instrWord_u  w;
      logic [31:0] r;
      logic [2:0]  sel;
      int          k, kind, off, hopMax;
      for (k = 0; k < progLen; k++) begin
         r = $random(seed);
         kind = pick(seed, 16);
         sel = r[11:9];
         w = '0;
         w.r.rd = {2'b00, r[2:0]};  // x0..x7 keeps hazards dense
         w.r.rs1 = {2'b00, r[5:3]};
         w.r.rs2 = {2'b00, r[8:6]};
         if (kind < 4) begin
            w.r.opcode = opReg;
            w.r.funct3 = aluF3[sel];
            w.r.funct7 = (sel == 3'd1) ? 7'h20 : 7'h00;
         end else if (kind < 8) begin
            w.i.opcode = opImm;
            w.i.funct3 = aluF3[sel];
            w.i.imm = (sel >= 3'd6) ? {7'd0, r[16:12]} : r[23:12];  // shifts take shamt
         end else if (kind == 8) begin
            w.u.opcode = opLui;
            w.u.imm = r[31:12];
         end else if (kind < 11) begin
            w.i.opcode = opLoad;
            w.i.funct3 = 3'b010;
            w.i.rs1 = 5'd0;
            w.i.imm = 12'(pick(seed, 64) * 4);
         end else if (kind < 13) begin
            off = pick(seed, 64) * 4;
            w.s.opcode = opStore;
            w.s.funct3 = 3'b010;
            w.s.rs1 = 5'd0;
            w.s.immHi = off[11:5];
            w.s.immLo = off[4:0];
         end else begin
            // forward only, never past the ebreak
            hopMax = (progLen - k < 8) ? progLen - k : 8;
            off = (1 + pick(seed, hopMax)) * 4;
            if (kind < 15) begin
               w.b.opcode = opBranch;
               w.b.funct3 = {2'b00, r[12]};
               w.b.imm11 = 1'b0;
               w.b.imm10_5 = off[10:5];
               w.b.imm4_1 = off[4:1];
            end else begin
               w.j.opcode = opJal;
               w.j.imm10_1 = off[10:1];
               w.j.imm11 = 1'b0;
               w.j.imm19_12 = 8'd0;
            end
         end
         prog[k] = w;
      end
      prog[progLen] = haltInstr;
   endtask

   task automatic runModel();
      instrWord_u  w;
      logic [31:0] regs [0:31];
      logic [31:0] pc, nextPc, a, b, addr, iImm, sImm, bImm, jImm;
      wrEntry_t    e;
      int          i;
      bit          done;
      for (i = 0; i < 32; i++)
         regs[i] = 32'd0;
      for (i = 0; i < memWords; i++)
         modelMem[i] = dataFill(i);
      expWrites.delete();
      retired = 0;
      pc = 32'd0;
      done = 1'b0;
      while (!done) begin
         w = prog[pc[31:2]];
         a = regs[w.r.rs1];
         b = regs[w.r.rs2];
         iImm = {{20{w.i.imm[11]}}, w.i.imm};
         sImm = {{20{w.s.immHi[6]}}, w.s.immHi, w.s.immLo};
         bImm = {{20{w.b.imm12}}, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
         jImm = {{12{w.j.imm20}}, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
         e = '0;
         nextPc = pc + 32'd4;
         retired++;
         done = (w == haltInstr);
         case (w.r.opcode)
            opReg: e = {2'd0, w.r.rd, aluModel(w.r.funct3, w.r.funct7[5], a, b)};
            opImm: e = {2'd0, w.i.rd, aluModel(w.i.funct3, 1'b0, a, iImm)};
            opLui: e = {2'd0, w.u.rd, w.u.imm, 12'd0};
            opLoad: begin
               addr = a + iImm;
               e = {2'd1, w.i.rd, modelMem[addr[11:2]]};
            end
            opStore: begin
               addr = a + sImm;
               modelMem[addr[11:2]] = b;
            end
            opBranch: begin
               if ((a == b) != w.b.funct3[0])
                  nextPc = pc + bImm;
            end
            opJal: begin
               e = {2'd2, w.j.rd, pc + 32'd4};
               nextPc = pc + jImm;
            end
            default: ;
         endcase
         if (e.wa != 5'd0) begin
            expWrites.push_back(e);
            regs[e.wa] = e.wd;
         end
         pc = nextPc;
      end
   endtask

endpackage

//--- tests/tbTop.sv
`timescale 1ns/1ps

module tbTop;
   import riscvPkg::*;
   import tbModel::*;

   localparam int cycleLimit = 3 * (progLen + 1) + 50;

   logic                 CLK;
   logic                 RSTn;
   logic                 iMemCsn, dMemCsn, dMemWen, rfWe, halt;
   logic [addrWidth-1:0] iMemAddr, dMemAddr;
   logic [31:0]          iMemData, dMemData, dMemDout, rfRd1, rfRd2, rfWd, numInst;
   logic [4:0]           rfRa1, rfRa2, rfWa;

   logic [31:0] iMem [0:memWords-1];
   logic [31:0] dMem [0:memWords-1];
   logic [31:0] regs [0:31];
   integer      seed;
   int          errs [1:5];
   int          checks;
   int          cycles;

   riscvTop UUT (
      .CLK, .RSTn, .iMemCsn, .iMemAddr, .iMemData, .dMemCsn, .dMemAddr, .dMemDout,
      .dMemData, .dMemWen, .rfWe, .rfRa1, .rfRa2, .rfWa, .rfRd1, .rfRd2, .rfWd,
      .halt, .numInst
   );

   always #5 CLK = ~CLK;

   // same-cycle reads
   assign iMemData = (iMemCsn === 1'b0) ? iMem[iMemAddr[addrWidth-1:2]] : 32'd0;
   assign dMemData = (dMemCsn === 1'b0) ? dMem[dMemAddr[9:0]] : 32'd0;
   assign rfRd1    = $isunknown(rfRa1) ? 32'd0 : regs[rfRa1];
   assign rfRd2    = $isunknown(rfRa2) ? 32'd0 : regs[rfRa2];

   always @(posedge CLK) begin
      if (rfWe === 1'b1 && rfWa != 5'd0)  // x0 stays zero
         regs[rfWa] <= rfWd;
      if (dMemCsn === 1'b0 && dMemWen === 1'b0)
         dMem[dMemAddr[9:0]] <= dMemDout;
   end

   task automatic checkResetOutputs();
      checks += 4;
      assert (rfWe === 1'b0) else begin
         $display("ERROR rfWe: got %h expected %h", rfWe, 1'b0);
         errs[1]++;
      end
      assert (dMemWen === 1'b1) else begin
         $display("ERROR dMemWen: got %h expected %h", dMemWen, 1'b1);
         errs[1]++;
      end
      assert (dMemCsn === 1'b1) else begin
         $display("ERROR dMemCsn: got %h expected %h", dMemCsn, 1'b1);
         errs[1]++;
      end
      assert (halt === 1'b0) else begin
         $display("ERROR halt: got %h expected %h", halt, 1'b0);
         errs[1]++;
      end
   endtask

   task automatic checkWrite();
      wrEntry_t exp;
      int       t;
      assert (expWrites.size() > 0) else begin
         $display("extra register write to x%0d after all expected writes", rfWa);
         errs[3]++;
      end
      if (expWrites.size() > 0) begin
         exp = expWrites.pop_front();
         t = (exp.kind == 2'd1) ? 4 : (exp.kind == 2'd2) ? 3 : 2;
         checks += 2;
         assert (rfWa == exp.wa) else begin
            $display("ERROR rfWa: got %h expected %h", rfWa, exp.wa);
            errs[t]++;
         end
         assert (rfWd == exp.wd) else begin
            $display("ERROR rfWd: got %h expected %h", rfWd, exp.wd);
            errs[t]++;
         end
      end
   endtask

   task automatic reportTest(input int n, input string name);
      $display("test %0d %s: %s, %0d errors", n, name, (errs[n] == 0) ? "ok" : "FAILED",
               errs[n]);
   endtask

   // sampled mid-cycle where the WB outputs are settled
   always @(negedge CLK) begin
      if (RSTn === 1'b0 && rfWe === 1'b1)
         checkWrite();
   end

   initial begin
      cycles = 0;
      wait (RSTn === 1'b0);
      while (cycles < cycleLimit) begin
         @(posedge CLK);
         cycles++;
      end
      $display("timeout: halt did not rise within %0d cycles", cycleLimit);
      $display("sim failed");
      $finish;
   end

   initial begin
      int a;
      int total;
      CLK = 1'b0;
      RSTn = 1'b1;
      seed = 32'h934945bb;
      checks = 0;
      errs = '{default: 0};
      genProgram(seed);
      runModel();
      for (a = 0; a < memWords; a++) begin
         iMem[a] = (a <= progLen) ? prog[a] : nopInstr;  // nops past the ebreak
         dMem[a] = dataFill(a);
      end
      for (a = 0; a < 32; a++)
         regs[a] = 32'd0;
      repeat (2) begin
         @(negedge CLK);
         checkResetOutputs();
      end
      RSTn = 1'b0;
      @(negedge CLK);
      checks += 3;
      assert (numInst === 32'd0) else begin
         $display("ERROR numInst: got %h expected %h", numInst, 32'd0);
         errs[1]++;
      end
      assert (iMemCsn === 1'b0) else begin
         $display("ERROR iMemCsn: got %h expected %h", iMemCsn, 1'b0);
         errs[1]++;
      end
      assert (iMemAddr === '0) else begin
         $display("ERROR iMemAddr: got %h expected %h", iMemAddr, 12'h000);
         errs[1]++;
      end
      reportTest(1, "reset outputs");

      while (halt !== 1'b1)
         @(negedge CLK);
      checks += 2;
      assert (expWrites.size() == 0) else begin
         $display("%0d expected register writes never appeared", expWrites.size());
         errs[5]++;
      end
      assert (numInst == retired) else begin
         $display("ERROR numInst: got %h expected %h", numInst, retired);
         errs[5]++;
      end
      for (a = 0; a < memWords; a++) begin
         checks++;
         assert (dMem[a] == modelMem[a]) else begin
            $display("ERROR dMem[%h]: got %h expected %h", a, dMem[a], modelMem[a]);
            errs[4]++;
         end
      end
      reportTest(2, "register writes in order");
      reportTest(3, "squashed instructions");
      reportTest(4, "loads, stores and load-use");
      reportTest(5, "halt and retire count");
      total = 0;
      for (a = 1; a <= 5; a++)
         total += errs[a];
      $display("%0d checks, %0d errors", checks, total);
      if (total == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- verilog.f
source/riscvPkg.sv
source/fetchUnit.sv
source/instrDecode.sv
source/execUnit.sv
source/writeBack.sv
source/riscvTop.sv
tests/tbModel.sv
tests/tbTop.sv

//--- Bender.yml
package:
  name: rv32i_pipe

sources:
  - source/riscvPkg.sv
  - source/fetchUnit.sv
  - source/instrDecode.sv
  - source/execUnit.sv
  - source/writeBack.sv
  - source/riscvTop.sv
  - target: test
    files:
      - tests/tbModel.sv
      - tests/tbTop.sv
